// ==== compile.f ====
verilog/xbar_pkg.sv
verilog/mem_req_if.sv
verilog/port_mux.sv
verilog/id_remap.sv
verilog/port_concentrator_top.sv
dv/port_concentrator_assertions.sv
dv/tb_port_concentrator.sv

// ==== dv/port_concentrator_assertions.sv ====
// Protocol, fairness and stability checks, bound into the concentrator top
// Fairness relies on requesters holding valid until accepted
`timescale 1ns/1ps
`default_nettype none

module port_concentrator_assertions import xbar_pkg::*; #(
  parameter int unsigned NumPorts   = 4,
  parameter int unsigned InIdWidth  = 2,
  parameter int unsigned MaxUniqIds = 4,
  localparam int unsigned OutIdWidth = $clog2(MaxUniqIds)
) (
  input logic                                 clk_i,
  input logic                                 reset_i,
  input logic    [NumPorts-1:0]               port_req_valid_i,
  input logic    [NumPorts-1:0]               port_req_ready_o,
  input logic    [NumPorts-1:0]               port_rsp_valid_o,
  input logic    [NumPorts-1:0]               port_rsp_ready_i,
  input logic    [NumPorts-1:0][DataWidth-1:0] port_rsp_rdata_o,
  input logic    [NumPorts-1:0][InIdWidth-1:0] port_rsp_id_o,
  input logic                                 ext_req_valid_o,
  input logic                                 ext_req_ready_i,
  input logic    [AddrWidth-1:0]              ext_req_addr_o,
  input mem_op_e                              ext_req_op_o,
  input logic    [DataWidth-1:0]              ext_req_wdata_o,
  input logic    [OutIdWidth-1:0]             ext_req_id_o,
  input logic                                 ext_rsp_ready_o
);

  // Row p marks ports that waited while p was granted
  logic [NumPorts-1:0][NumPorts-1:0] owed_q;

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      for (int q = 0; q < NumPorts; q++) begin
        if (reset_i || port_req_ready_o[q]) begin
          owed_q[p][q] <= 1'b0;
        end else if (p != q && port_req_ready_o[p] && port_req_valid_i[q]) begin
          owed_q[p][q] <= 1'b1;
        end
      end
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assert property (@(posedge clk_i) disable iff (reset_i)
      !(port_req_ready_o[p] && owed_q[p] != '0))
      else $error("port %0d granted twice while another port waited", p);

    assert property (@(posedge clk_i) disable iff (reset_i)
      port_rsp_valid_o[p] && !port_rsp_ready_i[p] |->
      !ext_rsp_ready_o ##1 port_rsp_valid_o[p] && $stable(port_rsp_rdata_o[p]) &&
      $stable(port_rsp_id_o[p]))
      else $error("response on port %0d changed under back-pressure", p);
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    ext_req_valid_o && !ext_req_ready_i |=> ext_req_valid_o && $stable(ext_req_addr_o) &&
    $stable(ext_req_op_o) && $stable(ext_req_wdata_o) && $stable(ext_req_id_o))
    else $error("ext request changed while stalled");

endmodule

bind port_concentrator_top port_concentrator_assertions #(
  .NumPorts   ( NumPorts   ),
  .InIdWidth  ( InIdWidth  ),
  .MaxUniqIds ( MaxUniqIds )
) u_assertions (.*);

`default_nettype wire

// ==== dv/tb_port_concentrator.sv ====
// Random traffic on all ports against a reordering memory model with a scoreboard
// Same-index responses leave the model in order, as the bus requires per ID
`timescale 1ns/1ps
`default_nettype none

module tb_port_concentrator import xbar_pkg::*;;

  localparam int unsigned NumPorts     = 4;
  localparam int unsigned InIdWidth    = 2;
  localparam int unsigned MaxUniqIds   = 4;
  localparam int unsigned MaxTxnsPerId = 2;
  localparam int unsigned OutIdWidth   = 2;
  localparam int unsigned NumKeys      = NumPorts * (1 << InIdWidth);
  localparam int unsigned ReqsPerPort  = 150;
  localparam int unsigned CycleLimit   = 20000;

  logic                                 clk_i;
  logic                                 reset_i;
  logic    [NumPorts-1:0]               port_req_valid_i;
  logic    [NumPorts-1:0]               port_req_ready_o;
  logic    [NumPorts-1:0][AddrWidth-1:0] port_req_addr_i;
  mem_op_e [NumPorts-1:0]               port_req_op_i;
  logic    [NumPorts-1:0][DataWidth-1:0] port_req_wdata_i;
  logic    [NumPorts-1:0][InIdWidth-1:0] port_req_id_i;
  logic    [NumPorts-1:0]               port_rsp_valid_o;
  logic    [NumPorts-1:0]               port_rsp_ready_i;
  logic    [NumPorts-1:0][DataWidth-1:0] port_rsp_rdata_o;
  logic    [NumPorts-1:0][InIdWidth-1:0] port_rsp_id_o;
  logic                                 ext_req_valid_o;
  logic                                 ext_req_ready_i;
  logic    [AddrWidth-1:0]              ext_req_addr_o;
  mem_op_e                              ext_req_op_o;
  logic    [DataWidth-1:0]              ext_req_wdata_o;
  logic    [OutIdWidth-1:0]             ext_req_id_o;
  logic                                 ext_rsp_valid_i;
  logic                                 ext_rsp_ready_o;
  logic    [DataWidth-1:0]              ext_rsp_rdata_i;
  logic    [OutIdWidth-1:0]             ext_rsp_id_i;

  logic [31:0] lfsr_q;
  // Memory model and scoreboard state
  logic [DataWidth-1:0] model_mem [logic [AddrWidth-1:0]];
  logic [DataWidth-1:0] shadow_mem [logic [AddrWidth-1:0]];
  logic [OutIdWidth-1:0] slot_id [$];
  logic [DataWidth-1:0] slot_data [$];
  logic [DataWidth-1:0] exp_q [NumKeys][$];
  int unsigned live_cnt [NumKeys];
  int unsigned launched [NumPorts];
  logic [NumPorts-1:0] accepted;
  logic rsp_taken;
  int unsigned received;

  port_concentrator_top #(
    .NumPorts     ( NumPorts     ),
    .InIdWidth    ( InIdWidth    ),
    .MaxUniqIds   ( MaxUniqIds   ),
    .MaxTxnsPerId ( MaxTxnsPerId )
  ) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] get_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_idle_outputs();
    if (ext_req_valid_o !== 1'b0 || port_rsp_valid_o !== '0) begin
      fail_run($sformatf("MISMATCH at %0t: ext_req_valid/port_rsp_valid exp 0/0 got %b/%b",
                         $time, ext_req_valid_o, port_rsp_valid_o));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling at the falling edge, transfers happen on the next rise
  ////////////////////////////////////////////////////////////

  task automatic sample_cycle();
    logic [DataWidth-1:0] rd;
    int unsigned key;
    int unsigned busy;
    if (ext_req_valid_o && ext_req_ready_i) begin
      if (ext_req_op_o == OP_WRITE) begin
        model_mem[ext_req_addr_o] = ext_req_wdata_o;
        rd = '0;
      end else begin
        rd = model_mem.exists(ext_req_addr_o) ? model_mem[ext_req_addr_o] : '0;
      end
      slot_id.push_back(ext_req_id_o);
      slot_data.push_back(rd);
    end
    accepted = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (port_req_valid_i[p] && port_req_ready_o[p]) begin
        key = p * (1 << InIdWidth) + int'(port_req_id_i[p]);
        if (port_req_op_i[p] == OP_WRITE) begin
          shadow_mem[port_req_addr_i[p]] = port_req_wdata_i[p];
          exp_q[key].push_back('0);
        end else begin
          exp_q[key].push_back(shadow_mem.exists(port_req_addr_i[p]) ?
                               shadow_mem[port_req_addr_i[p]] : '0);
        end
        live_cnt[key]++;
        accepted[p] = 1'b1;
      end
      if (port_rsp_valid_o[p] && port_rsp_ready_i[p]) begin
        key = p * (1 << InIdWidth) + int'(port_rsp_id_o[p]);
        if (exp_q[key].size() == 0) begin
          fail_run($sformatf("Response on port %0d with ID %0d that has nothing outstanding",
                             p, port_rsp_id_o[p]));
        end
        if (port_rsp_rdata_o[p] !== exp_q[key][0]) begin
          fail_run($sformatf("MISMATCH at %0t: port_rsp_rdata_o[%0d] exp %h got %h",
                             $time, p, exp_q[key][0], port_rsp_rdata_o[p]));
        end
        void'(exp_q[key].pop_front());
        live_cnt[key]--;
        received++;
      end
    end
    // Response leaves the bus after the coming rising edge
    rsp_taken = ext_rsp_valid_i && ext_rsp_ready_o;
    // Remap table limits, seen from the wide IDs in flight
    busy = 0;
    for (int k = 0; k < NumKeys; k++) begin
      if (live_cnt[k] > MaxTxnsPerId) begin
        fail_run($sformatf("Wide ID %0d has %0d requests in flight", k, live_cnt[k]));
      end
      if (live_cnt[k] != 0) begin
        busy++;
      end
    end
    if (busy > MaxUniqIds) begin
      fail_run($sformatf("%0d distinct wide IDs in flight, table has %0d", busy, MaxUniqIds));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Driving after the rising edge
  ////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    logic [31:0] r;
    int j;
    int i;
    if (rsp_taken) begin
      ext_rsp_valid_i = 1'b0;
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (!port_req_valid_i[p] || accepted[p]) begin
        port_req_valid_i[p] = 1'b0;
        r = get_bits(2);
        if (launched[p] < ReqsPerPort && r[1:0] != 2'b00) begin
          r = get_bits(1);
          port_req_op_i[p] = mem_op_e'(r[0]);
          r = get_bits(InIdWidth);
          port_req_id_i[p] = r[InIdWidth-1:0];
          r = get_bits(3);
          port_req_addr_i[p] = {27'd0, r[2:0], 2'b00};
          r = get_bits(32);
          port_req_wdata_i[p] = r;
          port_req_valid_i[p] = 1'b1;
          launched[p]++;
        end
      end
      r = get_bits(2);
      port_rsp_ready_i[p] = (r[1:0] != 2'b00);
    end
    r = get_bits(2);
    ext_req_ready_i = (slot_id.size() < 4) && (r[1:0] != 2'b00);
    r = get_bits(1);
    if (!ext_rsp_valid_i && slot_id.size() > 0 && r[0]) begin
      r = get_bits(2);
      j = int'(r[1:0]) % slot_id.size();
      i = 0;
      while (slot_id[i] != slot_id[j]) begin
        i++;
      end
      ext_rsp_valid_i = 1'b1;
      ext_rsp_id_i    = slot_id[i];
      ext_rsp_rdata_i = slot_data[i];
      slot_id.delete(i);
      slot_data.delete(i);
    end
  endtask

  initial begin
    int cycles;
    bit done;
    lfsr_q           = 32'h1599;
    reset_i          = 1'b1;
    port_req_valid_i = '0;
    port_req_addr_i  = '0;
    port_req_wdata_i = '0;
    port_req_id_i    = '0;
    port_rsp_ready_i = '0;
    ext_req_ready_i  = 1'b0;
    ext_rsp_valid_i  = 1'b0;
    ext_rsp_rdata_i  = '0;
    ext_rsp_id_i     = '0;
    accepted         = '0;
    rsp_taken        = 1'b0;
    received         = 0;
    for (int p = 0; p < NumPorts; p++) begin
      port_req_op_i[p] = OP_READ;
      launched[p]      = 0;
    end
    for (int k = 0; k < NumKeys; k++) begin
      live_cnt[k] = 0;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    check_idle_outputs();
    @(posedge clk_i);
    #1 reset_i = 1'b0;
    @(negedge clk_i);
    check_idle_outputs();
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < CycleLimit) begin
      @(posedge clk_i);
      #1 drive_cycle();
      @(negedge clk_i);
      sample_cycle();
      cycles++;
      done = (received == NumPorts * ReqsPerPort);
    end
    if (!done) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d responses received",
                         cycles, received));
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the concentrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -sv -f compile.f \
    --top-module tb_port_concentrator -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

out="$(./obj_dir/Vtb_port_concentrator 2>&1)"
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
  exit 0
fi
exit 1

// ==== verilog/id_remap.sv ====
// Narrows wide IDs to table indices, MaxUniqIds must be 2 or more
// Response IDs must name a live entry, stale indices are not checked
`timescale 1ns/1ps
`default_nettype none

module id_remap import xbar_pkg::*; #(
  parameter int unsigned MuxIdWidth   = 4,
  parameter int unsigned MaxUniqIds   = 4,
  parameter int unsigned MaxTxnsPerId = 2,
  localparam int unsigned OutIdWidth  = $clog2(MaxUniqIds)
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  mem_req_if.slave              in_i,
  output logic                  ext_req_valid_o,
  input  logic                  ext_req_ready_i,
  output logic [AddrWidth-1:0]  ext_req_addr_o,
  output mem_op_e               ext_req_op_o,
  output logic [DataWidth-1:0]  ext_req_wdata_o,
  output logic [OutIdWidth-1:0] ext_req_id_o,
  input  logic                  ext_rsp_valid_i,
  output logic                  ext_rsp_ready_o,
  input  logic [DataWidth-1:0]  ext_rsp_rdata_i,
  input  logic [OutIdWidth-1:0] ext_rsp_id_i
);

  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  // Wide ID per entry, entry is live while its count is nonzero
  logic [MuxIdWidth-1:0]   tbl_id_q  [MaxUniqIds];
  logic [CntWidth-1:0]     tbl_cnt_q [MaxUniqIds];

  logic                    match_hit;
  logic [OutIdWidth-1:0]   match_idx;
  logic                    match_full;
  logic                    free_found;
  logic [OutIdWidth-1:0]   free_idx;
  logic                    hold_q;
  logic [OutIdWidth-1:0]   hold_idx_q;
  logic                    alloc_ok;
  logic [OutIdWidth-1:0]   sel_idx;
  logic                    req_fire;
  logic                    rsp_fire;
  logic [MaxUniqIds-1:0]   alloc_hit;
  logic [MaxUniqIds-1:0]   release_hit;

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    match_hit  = 1'b0;
    match_idx  = '0;
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = 0; i < MaxUniqIds; i++) begin
      if (!match_hit && tbl_cnt_q[i] != '0 && tbl_id_q[i] == in_i.req_id) begin
        match_hit = 1'b1;
        match_idx = OutIdWidth'(i);
      end
      if (!free_found && tbl_cnt_q[i] == '0) begin
        free_found = 1'b1;
        free_idx   = OutIdWidth'(i);
      end
    end
  end

  assign match_full = (tbl_cnt_q[match_idx] == CntWidth'(MaxTxnsPerId));

  // A stalled request keeps its index so ext_req_id stays stable
  assign alloc_ok = hold_q || (match_hit ? !match_full : free_found);
  assign sel_idx  = hold_q ? hold_idx_q : (match_hit ? match_idx : free_idx);

  assign ext_req_valid_o = in_i.req_valid && alloc_ok;
  assign in_i.req_ready  = ext_req_ready_i && alloc_ok;
  assign ext_req_addr_o  = in_i.req_addr;
  assign ext_req_op_o    = in_i.req_op;
  assign ext_req_wdata_o = in_i.req_wdata;
  assign ext_req_id_o    = sel_idx;

  assign req_fire = ext_req_valid_o && ext_req_ready_i;
  assign rsp_fire = ext_rsp_valid_i && ext_rsp_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q     <= ext_req_valid_o && !ext_req_ready_i;
      hold_idx_q <= sel_idx;
    end
  end

  ////////////////////////////////////////////////////////////
  // Table update
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < MaxUniqIds; g++) begin : gen_entry
    assign alloc_hit[g]   = req_fire && (sel_idx == OutIdWidth'(g));
    assign release_hit[g] = rsp_fire && (ext_rsp_id_i == OutIdWidth'(g));
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < MaxUniqIds; i++) begin
        tbl_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < MaxUniqIds; i++) begin
        if (alloc_hit[i] && !release_hit[i]) begin
          tbl_cnt_q[i] <= tbl_cnt_q[i] + 1'b1;
        end else if (release_hit[i] && !alloc_hit[i]) begin
          tbl_cnt_q[i] <= tbl_cnt_q[i] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < MaxUniqIds; i++) begin
      if (alloc_hit[i]) begin
        tbl_id_q[i] <= in_i.req_id;
      end
    end
  end

  // Restore wide ID on the way back
  assign in_i.rsp_valid  = ext_rsp_valid_i;
  assign in_i.rsp_rdata  = ext_rsp_rdata_i;
  assign in_i.rsp_id     = tbl_id_q[ext_rsp_id_i];
  assign ext_rsp_ready_o = in_i.rsp_ready;

endmodule

`default_nettype wire

// ==== verilog/mem_req_if.sv ====
// Single channel request/response bus, valid/ready on each direction
// Responses may return out of order and are matched by ID only
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import xbar_pkg::*; #(
  parameter int unsigned IdWidth = 4
) ();

  // Request channel
  logic                 req_valid;
  logic                 req_ready;
  logic [AddrWidth-1:0] req_addr;
  mem_op_e              req_op;
  logic [DataWidth-1:0] req_wdata;
  logic [IdWidth-1:0]   req_id;

  // Response channel
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [DataWidth-1:0] rsp_rdata;
  logic [IdWidth-1:0]   rsp_id;

  // Requester side
  modport master (
    output req_valid, req_addr, req_op, req_wdata, req_id, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata, rsp_id
  );

  // Completer side
  modport slave (
    input  req_valid, req_addr, req_op, req_wdata, req_id, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata, rsp_id
  );

endinterface

`default_nettype wire

// ==== verilog/port_concentrator_top.sv ====
// Merges NumPorts requesters onto one memory port with narrowed IDs
// NumPorts and MaxUniqIds must both be 2 or more
`timescale 1ns/1ps
`default_nettype none

module port_concentrator_top import xbar_pkg::*; #(
  parameter int unsigned NumPorts     = 4,
  parameter int unsigned InIdWidth    = 2,
  parameter int unsigned MaxUniqIds   = 4,
  parameter int unsigned MaxTxnsPerId = 2,
  localparam int unsigned OutIdWidth  = $clog2(MaxUniqIds)
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // Requester ports
  input  logic    [NumPorts-1:0]               port_req_valid_i,
  output logic    [NumPorts-1:0]               port_req_ready_o,
  input  logic    [NumPorts-1:0][AddrWidth-1:0] port_req_addr_i,
  input  mem_op_e [NumPorts-1:0]               port_req_op_i,
  input  logic    [NumPorts-1:0][DataWidth-1:0] port_req_wdata_i,
  input  logic    [NumPorts-1:0][InIdWidth-1:0] port_req_id_i,
  output logic    [NumPorts-1:0]               port_rsp_valid_o,
  input  logic    [NumPorts-1:0]               port_rsp_ready_i,
  output logic    [NumPorts-1:0][DataWidth-1:0] port_rsp_rdata_o,
  output logic    [NumPorts-1:0][InIdWidth-1:0] port_rsp_id_o,
  // Memory port
  output logic                                 ext_req_valid_o,
  input  logic                                 ext_req_ready_i,
  output logic    [AddrWidth-1:0]              ext_req_addr_o,
  output mem_op_e                              ext_req_op_o,
  output logic    [DataWidth-1:0]              ext_req_wdata_o,
  output logic    [OutIdWidth-1:0]             ext_req_id_o,
  input  logic                                 ext_rsp_valid_i,
  output logic                                 ext_rsp_ready_o,
  input  logic    [DataWidth-1:0]              ext_rsp_rdata_i,
  input  logic    [OutIdWidth-1:0]             ext_rsp_id_i
);

  // Port index widens the requester ID
  localparam int unsigned MuxIdWidth = InIdWidth + $clog2(NumPorts);

  mem_req_if #(.IdWidth(MuxIdWidth)) mux_if ();

  port_mux #(
    .NumPorts  ( NumPorts  ),
    .InIdWidth ( InIdWidth )
  ) u_port_mux (
    .clk_i            ( clk_i            ),
    .reset_i          ( reset_i          ),
    .port_req_valid_i ( port_req_valid_i ),
    .port_req_ready_o ( port_req_ready_o ),
    .port_req_addr_i  ( port_req_addr_i  ),
    .port_req_op_i    ( port_req_op_i    ),
    .port_req_wdata_i ( port_req_wdata_i ),
    .port_req_id_i    ( port_req_id_i    ),
    .port_rsp_valid_o ( port_rsp_valid_o ),
    .port_rsp_ready_i ( port_rsp_ready_i ),
    .port_rsp_rdata_o ( port_rsp_rdata_o ),
    .port_rsp_id_o    ( port_rsp_id_o    ),
    .mux_o            ( mux_if.master    )
  );

  id_remap #(
    .MuxIdWidth   ( MuxIdWidth   ),
    .MaxUniqIds   ( MaxUniqIds   ),
    .MaxTxnsPerId ( MaxTxnsPerId )
  ) u_id_remap (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .in_i            ( mux_if.slave    ),
    .ext_req_valid_o ( ext_req_valid_o ),
    .ext_req_ready_i ( ext_req_ready_i ),
    .ext_req_addr_o  ( ext_req_addr_o  ),
    .ext_req_op_o    ( ext_req_op_o    ),
    .ext_req_wdata_o ( ext_req_wdata_o ),
    .ext_req_id_o    ( ext_req_id_o    ),
    .ext_rsp_valid_i ( ext_rsp_valid_i ),
    .ext_rsp_ready_o ( ext_rsp_ready_o ),
    .ext_rsp_rdata_i ( ext_rsp_rdata_i ),
    .ext_rsp_id_i    ( ext_rsp_id_i    )
  );

endmodule

`default_nettype wire

// ==== verilog/port_mux.sv ====
// Round-robin merge of NumPorts requesters, NumPorts must be 2 or more
// Requesters must hold valid and payload until accepted
`timescale 1ns/1ps
`default_nettype none

module port_mux import xbar_pkg::*; #(
  parameter int unsigned NumPorts  = 4,
  parameter int unsigned InIdWidth = 2
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic    [NumPorts-1:0]               port_req_valid_i,
  output logic    [NumPorts-1:0]               port_req_ready_o,
  input  logic    [NumPorts-1:0][AddrWidth-1:0] port_req_addr_i,
  input  mem_op_e [NumPorts-1:0]               port_req_op_i,
  input  logic    [NumPorts-1:0][DataWidth-1:0] port_req_wdata_i,
  input  logic    [NumPorts-1:0][InIdWidth-1:0] port_req_id_i,
  output logic    [NumPorts-1:0]               port_rsp_valid_o,
  input  logic    [NumPorts-1:0]               port_rsp_ready_i,
  output logic    [NumPorts-1:0][DataWidth-1:0] port_rsp_rdata_o,
  output logic    [NumPorts-1:0][InIdWidth-1:0] port_rsp_id_o,
  mem_req_if.master                            mux_o
);

  localparam int unsigned PortIdxWidth = $clog2(NumPorts);
  localparam int unsigned MuxIdWidth   = InIdWidth + PortIdxWidth;
  localparam int unsigned CandWidth    = PortIdxWidth + 1;

  logic [PortIdxWidth-1:0] rr_ptr_q;
  logic                    locked_q;
  logic [PortIdxWidth-1:0] lock_idx_q;
  logic                    gnt_valid;
  logic [PortIdxWidth-1:0] gnt_idx;
  logic                    req_fire;
  logic [PortIdxWidth-1:0] rsp_port;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // First valid port at or after the pointer, unless a grant is held
  always_comb begin
    logic [CandWidth-1:0] cand;
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    cand      = '0;
    if (locked_q) begin
      gnt_valid = port_req_valid_i[lock_idx_q];
      gnt_idx   = lock_idx_q;
    end else begin
      for (int k = 0; k < NumPorts; k++) begin
        cand = {1'b0, rr_ptr_q} + CandWidth'(k);
        if (cand >= CandWidth'(NumPorts)) begin
          cand = cand - CandWidth'(NumPorts);
        end
        if (!gnt_valid && port_req_valid_i[cand[PortIdxWidth-1:0]]) begin
          gnt_valid = 1'b1;
          gnt_idx   = cand[PortIdxWidth-1:0];
        end
      end
    end
  end

  assign req_fire = gnt_valid && mux_o.req_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q   <= '0;
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Hold the grant while the downstream stalls
      locked_q   <= gnt_valid && !mux_o.req_ready;
      lock_idx_q <= gnt_idx;
      if (req_fire) begin
        rr_ptr_q <= (gnt_idx == PortIdxWidth'(NumPorts - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  // Port index goes into the upper ID bits
  assign mux_o.req_valid = gnt_valid;
  assign mux_o.req_addr  = port_req_addr_i[gnt_idx];
  assign mux_o.req_op    = port_req_op_i[gnt_idx];
  assign mux_o.req_wdata = port_req_wdata_i[gnt_idx];
  assign mux_o.req_id    = {gnt_idx, port_req_id_i[gnt_idx]};

  ////////////////////////////////////////////////////////////
  // Response steering
  ////////////////////////////////////////////////////////////

  assign rsp_port        = mux_o.rsp_id[MuxIdWidth-1 -: PortIdxWidth];
  assign mux_o.rsp_ready = port_rsp_ready_i[rsp_port];

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assign port_req_ready_o[p] = req_fire && (gnt_idx == PortIdxWidth'(p));
    assign port_rsp_valid_o[p] = mux_o.rsp_valid && (rsp_port == PortIdxWidth'(p));
    assign port_rsp_rdata_o[p] = mux_o.rsp_rdata;
    assign port_rsp_id_o[p]    = mux_o.rsp_id[InIdWidth-1:0];
  end

endmodule

`default_nettype wire

// ==== verilog/xbar_pkg.sv ====
// Shared bus widths and opcodes for the request concentrator
// Byte addressed, one data word per request, no strobes or bursts
`default_nettype none

package xbar_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  // Byte address
  localparam int unsigned AddrWidth = 32;

  // One full word per transfer
  localparam int unsigned DataWidth = 32;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // Writes answer with zero rdata
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

endpackage

`default_nettype wire
